// ==== hdl/accumulatorPath.sv ====
`default_nettype none

module accumulatorPath (
  input  logic             CLK,
  input  logic             reset,
  input  logic             loadRegs,
  input  pdp8WordPkg::word acIn,
  input  logic             linkIn,
  input  pdp8WordPkg::word mqIn,
  input  pdp8WordPkg::word switches,
  input  logic             ev1,
  input  logic             ev2,
  input  logic             ev3,
  input  logic             ev4,
  input  logic             group1,
  input  logic             group2,
  input  logic             group3,
  input  logic             cla,
  input  logic             cll,
  input  logic             cma,
  input  logic             cml,
  input  logic             iac,
  input  logic             rar,
  input  logic             ral,
  input  logic             twice,
  input  logic             osr,
  input  logic             hlt,
  input  logic             mqa,
  input  logic             mql,
  input  logic             eaeOp,
  input  logic             skipCond,
  output pdp8WordPkg::word ac,
  output logic             link,
  output pdp8WordPkg::word mq,
  output logic             skip,
  output logic             halt,
  output logic             eaeTrap
);

  localparam int topBit = pdp8WordPkg::wordWidth;
  localparam int half   = pdp8WordPkg::halfWidth;

  pdp8WordPkg::linkWord linkAc;
  pdp8WordPkg::linkWord incremented;
  pdp8WordPkg::linkWord rotated;
  pdp8WordPkg::word     mqMoveAc;
  logic                 busy;
  logic                 skipPending;

  assign busy        = ev1 | ev2 | ev3 | ev4;
  assign linkAc      = {link, ac};
  assign incremented = linkAc + pdp8WordPkg::linkWord'(1);

  // ####################################################################
  // event 4 shifter.
  // ####################################################################

  // RAR and RAL together cancel.
  always_comb begin
    rotated = linkAc;
    if (rar && !ral) begin
      if (twice) begin
        rotated = {linkAc[1:0], linkAc[topBit:2]};
      end else begin
        rotated = {linkAc[0], linkAc[topBit:1]};
      end
    end else if (ral && !rar) begin
      if (twice) begin
        rotated = {linkAc[topBit-2:0], linkAc[topBit:topBit-1]};
      end else begin
        rotated = {linkAc[topBit-1:0], linkAc[topBit]};
      end
    end else if (twice && !rar && !ral) begin
      // BSW.
      rotated = {link, ac[half-1:0], ac[topBit-1:half]};
    end
  end

  // MQA and MQL both see the old AC and MQ.
  assign mqMoveAc = (mqa ? mq : '0) | (mql ? '0 : ac);

  // ####################################################################
  // register update.
  // ####################################################################

  always_ff @(posedge CLK) begin
    if (reset) begin
      ac          <= '0;
      link        <= 1'b0;
      mq          <= '0;
      skip        <= 1'b0;
      halt        <= 1'b0;
      eaeTrap     <= 1'b0;
      skipPending <= 1'b0;
    end else if (!busy) begin
      if (loadRegs) begin
        ac   <= acIn;
        link <= linkIn;
        mq   <= mqIn;
        halt <= 1'b0;
      end
    end else if (ev1) begin
      // skip tests AC before CLA takes effect.
      skipPending <= group2 & skipCond;
      if (cla) begin
        ac <= '0;
      end
      if (cll) begin
        link <= 1'b0;
      end
    end else if (ev2) begin
      if (group1) begin
        if (cma) begin
          ac <= ~ac;
        end
        if (cml) begin
          link <= ~link;
        end
      end
      if (group3) begin
        ac <= mqMoveAc;
        if (mql) begin
          mq <= ac;
        end
      end
    end else if (ev3) begin
      if (iac) begin
        {link, ac} <= incremented;
      end
      if (osr) begin
        ac <= ac | switches;
      end
    end else begin
      if (group1) begin
        {link, ac} <= rotated;
      end
      // status is in place together with done.
      skip    <= skipPending;
      eaeTrap <= eaeOp;
      if (hlt) begin
        halt <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/oprCtrlPkg.sv ====
`default_nettype none

package oprCtrlPkg;

  // ####################################################################
  // operate field positions, vector bit 0 is PDP-8 bit 11.
  // ####################################################################

  // group select bits.
  localparam int groupBit = 8;
  localparam int group2Select = 0;

  // micro-op fields shared between the groups.
  localparam int claBit = 7;
  localparam int clLorSma = 6;
  localparam int cmaOrSza = 5;
  localparam int cmlOrSnl = 4;
  localparam int rarOrInvert = 3;
  localparam int ralOrOsr = 2;
  localparam int twiceOrHlt = 1;
  localparam int iacOrGroup3 = 0;

  // ####################################################################
  // sequencer.
  // ####################################################################

  // micro events per instruction.
  localparam int eventCount = 4;

  typedef enum logic [2:0] {
    idle,
    event1,
    event2,
    event3,
    event4,
    finish
  } seqState;

endpackage

`default_nettype wire

// ==== hdl/oprDecoder.sv ====
`default_nettype none

module oprDecoder (
  input  pdp8WordPkg::word ir,
  input  logic             opr,
  output logic             group1,
  output logic             group2,
  output logic             group3,
  output logic             cla,
  output logic             cll,
  output logic             cma,
  output logic             cml,
  output logic             iac,
  output logic             rar,
  output logic             ral,
  output logic             twice,
  output logic             sma,
  output logic             sza,
  output logic             snl,
  output logic             invert,
  output logic             osr,
  output logic             hlt,
  output logic             mqa,
  output logic             mql,
  output logic             eaeOp
);

  logic eaeCode;

  // ####################################################################
  // group select.
  // ####################################################################

  assign group1 = opr & ~ir[oprCtrlPkg::groupBit];
  assign group2 = opr & ir[oprCtrlPkg::groupBit] & ~ir[oprCtrlPkg::group2Select];
  assign group3 = opr & ir[oprCtrlPkg::groupBit] & ir[oprCtrlPkg::group2Select];

  // CLA sits in the same place in every group.
  assign cla = opr & ir[oprCtrlPkg::claBit];

  // group 1.
  assign cll   = group1 & ir[oprCtrlPkg::clLorSma];
  assign cma   = group1 & ir[oprCtrlPkg::cmaOrSza];
  assign cml   = group1 & ir[oprCtrlPkg::cmlOrSnl];
  assign rar   = group1 & ir[oprCtrlPkg::rarOrInvert];
  assign ral   = group1 & ir[oprCtrlPkg::ralOrOsr];
  assign twice = group1 & ir[oprCtrlPkg::twiceOrHlt];
  assign iac   = group1 & ir[oprCtrlPkg::iacOrGroup3];

  // group 2.
  assign sma    = group2 & ir[oprCtrlPkg::clLorSma];
  assign sza    = group2 & ir[oprCtrlPkg::cmaOrSza];
  assign snl    = group2 & ir[oprCtrlPkg::cmlOrSnl];
  assign invert = group2 & ir[oprCtrlPkg::rarOrInvert];
  assign osr    = group2 & ir[oprCtrlPkg::ralOrOsr];
  assign hlt    = group2 & ir[oprCtrlPkg::twiceOrHlt];

  // group 3.
  assign mqa = group3 & ir[oprCtrlPkg::clLorSma];
  assign mql = group3 & ir[oprCtrlPkg::cmlOrSnl];

  // any EAE code in bits 1 to 3, or SCA, is not executed here.
  assign eaeCode = |ir[oprCtrlPkg::rarOrInvert:oprCtrlPkg::twiceOrHlt];
  assign eaeOp   = group3 & (ir[oprCtrlPkg::cmaOrSza] | eaeCode);

endmodule

`default_nettype wire

// ==== hdl/oprSequencer.sv ====
`default_nettype none

module oprSequencer (
  input  logic             CLK,
  input  logic             reset,
  input  logic             start,
  input  pdp8WordPkg::word ir,
  output pdp8WordPkg::word irHeld,
  output logic             busy,
  output logic             ev1,
  output logic             ev2,
  output logic             ev3,
  output logic             ev4,
  output logic             done
);

  oprCtrlPkg::seqState state;
  oprCtrlPkg::seqState nextState;
  logic [oprCtrlPkg::eventCount-1:0] evOneHot;
  logic accept;

  // start counts only when idle.
  assign accept = start && (state == oprCtrlPkg::idle);

  always_comb begin
    nextState = state;
    case (state)
      oprCtrlPkg::idle: begin
        if (accept) begin
          nextState = oprCtrlPkg::event1;
        end
      end
      oprCtrlPkg::event1: nextState = oprCtrlPkg::event2;
      oprCtrlPkg::event2: nextState = oprCtrlPkg::event3;
      oprCtrlPkg::event3: nextState = oprCtrlPkg::event4;
      oprCtrlPkg::event4: nextState = oprCtrlPkg::finish;
      oprCtrlPkg::finish: nextState = oprCtrlPkg::idle;
      default:            nextState = oprCtrlPkg::idle;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= oprCtrlPkg::idle;
    end else begin
      state <= nextState;
    end
  end

  // instruction stays put for the whole sequence.
  always_ff @(posedge CLK) begin
    if (accept) begin
      irHeld <= ir;
    end
  end

  // one strobe per micro event.
  assign evOneHot = {
    state == oprCtrlPkg::event4,
    state == oprCtrlPkg::event3,
    state == oprCtrlPkg::event2,
    state == oprCtrlPkg::event1
  };

  assign ev1  = evOneHot[0];
  assign ev2  = evOneHot[1];
  assign ev3  = evOneHot[2];
  assign ev4  = evOneHot[3];
  assign busy = |evOneHot;
  assign done = (state == oprCtrlPkg::finish);

endmodule

`default_nettype wire

// ==== hdl/oprUnit.sv ====
`default_nettype none

module oprUnit (
  input  logic             CLK,
  input  logic             reset,
  input  logic             start,
  input  pdp8WordPkg::word ir,
  input  pdp8WordPkg::word switches,
  input  logic             loadRegs,
  input  pdp8WordPkg::word acIn,
  input  logic             linkIn,
  input  pdp8WordPkg::word mqIn,
  output pdp8WordPkg::word ac,
  output logic             link,
  output pdp8WordPkg::word mq,
  output logic             skip,
  output logic             halt,
  output logic             eaeTrap,
  output logic             done,
  output logic             busy
);

  pdp8WordPkg::word irHeld;
  logic ev1, ev2, ev3, ev4;
  logic group1, group2, group3;
  logic cla, cll, cma, cml, iac, rar, ral, twice;
  logic sma, sza, snl, invert, osr, hlt;
  logic mqa, mql, eaeOp;
  logic skipCond;

  oprSequencer u_sequencer (
    .CLK    (CLK),
    .reset  (reset),
    .start  (start),
    .ir     (ir),
    .irHeld (irHeld),
    .busy   (busy),
    .ev1    (ev1),
    .ev2    (ev2),
    .ev3    (ev3),
    .ev4    (ev4),
    .done   (done)
  );

  // decode is live only while events run.
  oprDecoder u_decoder (
    .ir     (irHeld),
    .opr    (busy),
    .group1 (group1),
    .group2 (group2),
    .group3 (group3),
    .cla    (cla),
    .cll    (cll),
    .cma    (cma),
    .cml    (cml),
    .iac    (iac),
    .rar    (rar),
    .ral    (ral),
    .twice  (twice),
    .sma    (sma),
    .sza    (sza),
    .snl    (snl),
    .invert (invert),
    .osr    (osr),
    .hlt    (hlt),
    .mqa    (mqa),
    .mql    (mql),
    .eaeOp  (eaeOp)
  );

  skipEvaluator u_skipEval (
    .ac       (ac),
    .link     (link),
    .sma      (sma),
    .sza      (sza),
    .snl      (snl),
    .invert   (invert),
    .skipCond (skipCond)
  );

  accumulatorPath u_datapath (
    .CLK      (CLK),
    .reset    (reset),
    .loadRegs (loadRegs),
    .acIn     (acIn),
    .linkIn   (linkIn),
    .mqIn     (mqIn),
    .switches (switches),
    .ev1      (ev1),
    .ev2      (ev2),
    .ev3      (ev3),
    .ev4      (ev4),
    .group1   (group1),
    .group2   (group2),
    .group3   (group3),
    .cla      (cla),
    .cll      (cll),
    .cma      (cma),
    .cml      (cml),
    .iac      (iac),
    .rar      (rar),
    .ral      (ral),
    .twice    (twice),
    .osr      (osr),
    .hlt      (hlt),
    .mqa      (mqa),
    .mql      (mql),
    .eaeOp    (eaeOp),
    .skipCond (skipCond),
    .ac       (ac),
    .link     (link),
    .mq       (mq),
    .skip     (skip),
    .halt     (halt),
    .eaeTrap  (eaeTrap)
  );

endmodule

`default_nettype wire

// ==== hdl/pdp8WordPkg.sv ====
`default_nettype none

package pdp8WordPkg;

  // machine word width.
  localparam int wordWidth = 12;

  // byte swap exchanges the two halves of AC.
  localparam int halfWidth = wordWidth / 2;

  // AC, MQ, switches and the instruction register.
  typedef logic [wordWidth-1:0] word;

  // link sits above AC for increment and rotate.
  typedef logic [wordWidth:0] linkWord;

endpackage

`default_nettype wire

// ==== hdl/skipEvaluator.sv ====
`default_nettype none

module skipEvaluator (
  input  pdp8WordPkg::word ac,
  input  logic             link,
  input  logic             sma,
  input  logic             sza,
  input  logic             snl,
  input  logic             invert,
  output logic             skipCond
);

  logic acMinus;
  logic acZero;
  logic anyHit;

  // sign bit of AC.
  assign acMinus = ac[pdp8WordPkg::wordWidth-1];
  assign acZero  = (ac == '0);

  // OR group, SPA/SNA/SZL when reversed.
  assign anyHit = (sma & acMinus) | (sza & acZero) | (snl & link);

  // no test selected with invert set gives SKP.
  assign skipCond = anyHit ^ invert;

endmodule

`default_nettype wire

// ==== pdp8Opr.f ====
hdl/pdp8WordPkg.sv
hdl/oprCtrlPkg.sv
hdl/oprDecoder.sv
hdl/oprSequencer.sv
hdl/skipEvaluator.sv
hdl/accumulatorPath.sv
hdl/oprUnit.sv
sim/oprUnit_chk.sv
sim/oprUnitTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build the oprUnit testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module oprUnitTb -Mdir obj_dir -f pdp8Opr.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/VoprUnitTb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "test failed" "$logFile"; then
  exit 1
fi
exit 0

// ==== sim/oprUnitTb.sv ====
`default_nettype none

module oprUnitTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int resetCycles = 10;
  localparam int latency = 5;
  localparam int doneWait = 20;
  // directed and random runs, each with its preload and a spare cycle.
  localparam int plannedRuns = 420;
  localparam int runCycles = 9;
  localparam int testLength = resetCycles + plannedRuns * runCycles;
  localparam int timeoutLimit = 10 * testLength;

  logic CLK = 1'b0;
  logic reset;
  logic start;
  pdp8WordPkg::word ir;
  pdp8WordPkg::word switches;
  logic loadRegs;
  pdp8WordPkg::word acIn;
  logic linkIn;
  pdp8WordPkg::word mqIn;
  pdp8WordPkg::word ac;
  logic link;
  pdp8WordPkg::word mq;
  logic skip, halt, eaeTrap, done, busy;

  // register state as the model sees it.
  pdp8WordPkg::word mAc, mMq;
  logic mLink, mHalt;
  pdp8WordPkg::word expAc, expMq;
  logic expLink, expSkip, expHalt, expTrap;
  string curTest;
  logic [31:0] rngState;
  int cycleCount = 0;
  int compareChecks = 0;
  int compareErrors = 0;
  int stimulusErrors = 0;

  pdp8WordPkg::word skipOps [11] = '{12'o7500, 12'o7440, 12'o7420, 12'o7540, 12'o7560,
    12'o7510, 12'o7450, 12'o7430, 12'o7570, 12'o7410, 12'o7400};
  pdp8WordPkg::word skipAc [3] = '{12'o0000, 12'o4000, 12'o0123};
  pdp8WordPkg::word mqOps [8] = '{12'o7401, 12'o7421, 12'o7501, 12'o7521,
    12'o7601, 12'o7621, 12'o7701, 12'o7721};
  pdp8WordPkg::word eaeOps [9] = '{12'o7441, 12'o7403, 12'o7405, 12'o7407, 12'o7411,
    12'o7413, 12'o7415, 12'o7417, 12'o7641};

  oprUnit u_dut (
    .CLK      (CLK),
    .reset    (reset),
    .start    (start),
    .ir       (ir),
    .switches (switches),
    .loadRegs (loadRegs),
    .acIn     (acIn),
    .linkIn   (linkIn),
    .mqIn     (mqIn),
    .ac       (ac),
    .link     (link),
    .mq       (mq),
    .skip     (skip),
    .halt     (halt),
    .eaeTrap  (eaeTrap),
    .done     (done),
    .busy     (busy)
  );

  always #10 CLK = ~CLK;

  function automatic logic [31:0] lcgStep(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic pdp8WordPkg::word randomWord();
    rngState = lcgStep(rngState);
    return rngState[27:16];
  endfunction

  function automatic bit reportMismatch(input string testName, input string field,
      input logic [11:0] expected, input logic [11:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s %s expected %o actual %o", testName, field, expected, actual);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  // ####################################################################
  // reference model, result is {ac, link, mq, skip, halt, eaeTrap}.
  // ####################################################################

  function automatic logic [27:0] oprModel(input pdp8WordPkg::word instr,
      input pdp8WordPkg::word acOld, input logic linkOld, input pdp8WordPkg::word mqOld,
      input logic haltOld, input pdp8WordPkg::word sw);
    pdp8WordPkg::word a;
    pdp8WordPkg::word m;
    pdp8WordPkg::word mqNext;
    pdp8WordPkg::linkWord la;
    logic l, s, h, t, right, left, twice;
    int n;
    a = acOld;
    l = linkOld;
    m = mqOld;
    s = 1'b0;
    h = haltOld;
    t = 1'b0;
    if (!instr[oprCtrlPkg::groupBit]) begin
      if (instr[oprCtrlPkg::claBit]) a = '0;
      if (instr[oprCtrlPkg::clLorSma]) l = 1'b0;
      if (instr[oprCtrlPkg::cmaOrSza]) a = ~a;
      if (instr[oprCtrlPkg::cmlOrSnl]) l = ~l;
      la = {l, a};
      if (instr[oprCtrlPkg::iacOrGroup3]) la = la + 13'd1;
      right = instr[oprCtrlPkg::rarOrInvert];
      left = instr[oprCtrlPkg::ralOrOsr];
      twice = instr[oprCtrlPkg::twiceOrHlt];
      for (n = 0; n < (twice ? 2 : 1); n++) begin
        if (right && !left) la = {la[0], la[12:1]};
        if (left && !right) la = {la[11:0], la[12]};
      end
      // byte swap leaves the link alone.
      if (twice && !right && !left) la = {la[12], la[5:0], la[11:6]};
      {l, a} = la;
    end else if (!instr[oprCtrlPkg::group2Select]) begin
      // conditions see AC before the clear.
      s = (instr[oprCtrlPkg::clLorSma] & a[pdp8WordPkg::wordWidth-1])
        | (instr[oprCtrlPkg::cmaOrSza] & (a == '0))
        | (instr[oprCtrlPkg::cmlOrSnl] & l);
      s = s ^ instr[oprCtrlPkg::rarOrInvert];
      if (instr[oprCtrlPkg::claBit]) a = '0;
      if (instr[oprCtrlPkg::ralOrOsr]) a = a | sw;
      if (instr[oprCtrlPkg::twiceOrHlt]) h = 1'b1;
    end else begin
      if (instr[oprCtrlPkg::claBit]) a = '0;
      mqNext = instr[oprCtrlPkg::cmlOrSnl] ? a : m;
      a = (instr[oprCtrlPkg::clLorSma] ? m : 12'o0)
        | (instr[oprCtrlPkg::cmlOrSnl] ? 12'o0 : a);
      m = mqNext;
      t = instr[oprCtrlPkg::cmaOrSza]
        | (instr[oprCtrlPkg::rarOrInvert:oprCtrlPkg::twiceOrHlt] != 3'b000);
    end
    return {a, l, m, s, h, t};
  endfunction

  task automatic preloadRegs(input pdp8WordPkg::word acV, input logic linkV,
      input pdp8WordPkg::word mqV);
    loadRegs = 1'b1;
    acIn = acV;
    linkIn = linkV;
    mqIn = mqV;
    @(negedge CLK);
    loadRegs = 1'b0;
    mAc = acV;
    mLink = linkV;
    mMq = mqV;
    mHalt = 1'b0;
  endtask

  task automatic runInstruction(input string name, input pdp8WordPkg::word instr,
      input bit disturb);
    logic [27:0] expected;
    int waited;
    bit seen;
    expected = oprModel(instr, mAc, mLink, mMq, mHalt, switches);
    {expAc, expLink, expMq, expSkip, expHalt, expTrap} = expected;
    mAc = expAc;
    mLink = expLink;
    mMq = expMq;
    mHalt = expHalt;
    curTest = name;
    ir = instr;
    start = 1'b1;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < doneWait) begin
      @(negedge CLK);
      waited++;
      start = 1'b0;
      loadRegs = 1'b0;
      // a second start and a load in the middle of the sequence.
      if (disturb && waited == 2) begin
        start = 1'b1;
        ir = ~instr;
        loadRegs = 1'b1;
        acIn = ~expAc;
        linkIn = ~expLink;
        mqIn = ~expMq;
      end
      // busy covers the four event cycles only.
      if (reportMismatch(name, "busy", 12'(waited < latency), 12'(busy))) stimulusErrors++;
      seen = done;
    end
    if (!seen) begin
      $display("no done within %0d cycles of start in test %s", doneWait, name);
      stimulusErrors++;
    end else if (waited != latency) begin
      $display("done came %0d cycles after start in test %s, not %0d", waited, name, latency);
      stimulusErrors++;
    end
    // the done cycle is not idle yet.
    @(negedge CLK);
  endtask

  always @(negedge CLK) begin
    if (!reset && done) begin
      compareChecks++;
      if (reportMismatch(curTest, "ac", expAc, ac)) compareErrors++;
      if (reportMismatch(curTest, "link", 12'(expLink), 12'(link))) compareErrors++;
      if (reportMismatch(curTest, "mq", expMq, mq)) compareErrors++;
      if (reportMismatch(curTest, "skip", 12'(expSkip), 12'(skip))) compareErrors++;
      if (reportMismatch(curTest, "halt", 12'(expHalt), 12'(halt))) compareErrors++;
      if (reportMismatch(curTest, "eaeTrap", 12'(expTrap), 12'(eaeTrap))) compareErrors++;
    end
  end

  always @(posedge CLK) begin
    cycleCount++;
    if (cycleCount >= timeoutLimit) begin
      $display("run stopped at the limit of %0d cycles", timeoutLimit);
      $display("checks %0d, compare errors %0d, other errors %0d",
        compareChecks, compareErrors, stimulusErrors);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    int j;
    pdp8WordPkg::word w;
    reset = 1'b1;
    start = 1'b0;
    ir = '0;
    switches = '0;
    loadRegs = 1'b0;
    acIn = '0;
    linkIn = 1'b0;
    mqIn = '0;
    rngState = 32'h14445a3a;
    mAc = '0;
    mLink = 1'b0;
    mMq = '0;
    mHalt = 1'b0;
    {expAc, expLink, expMq, expSkip, expHalt, expTrap} = '0;
    curTest = "reset";
    repeat (resetCycles) @(negedge CLK);
    reset = 1'b0;
    if (reportMismatch("reset", "ac", 12'o0, ac)) stimulusErrors++;
    if (reportMismatch("reset", "link", 12'o0, 12'(link))) stimulusErrors++;
    if (reportMismatch("reset", "mq", 12'o0, mq)) stimulusErrors++;
    if (reportMismatch("reset", "status", 12'o0, 12'({skip, halt, eaeTrap}))) stimulusErrors++;
    if (reportMismatch("reset", "busy done", 12'o0, 12'({busy, done}))) stimulusErrors++;

    // ####################################################################
    // group 1.
    // ####################################################################
    preloadRegs(12'o1234, 1'b0, 12'o0);
    runInstruction("cla cma", 12'o7240, 1'b0);
    runInstruction("cla iac", 12'o7201, 1'b0);
    preloadRegs(12'o3777, 1'b0, 12'o0);
    runInstruction("iac ral", 12'o7005, 1'b0);
    preloadRegs(12'o0003, 1'b0, 12'o0);
    runInstruction("cml rtr", 12'o7032, 1'b0);
    preloadRegs(12'o1234, 1'b1, 12'o0);
    runInstruction("bsw", 12'o7002, 1'b0);
    runInstruction("rtl", 12'o7006, 1'b0);
    runInstruction("rar ral", 12'o7014, 1'b0);
    runInstruction("cll cml", 12'o7120, 1'b0);
    for (j = 0; j < 200; j++) begin
      if (j % 8 == 0) begin
        w = randomWord();
        preloadRegs(w, w[5], randomWord());
      end
      w = randomWord();
      runInstruction($sformatf("group1 %o", {4'b1110, w[7:0]}), {4'b1110, w[7:0]}, 1'b0);
    end

    // ####################################################################
    // group 2.
    // ####################################################################
    foreach (skipAc[acIdx]) begin
      for (j = 0; j < 2; j++) begin
        foreach (skipOps[opIdx]) begin
          preloadRegs(skipAc[acIdx], 1'(j), 12'o0);
          runInstruction($sformatf("skip %o ac %o link %0d", skipOps[opIdx], skipAc[acIdx], j),
            skipOps[opIdx], 1'b0);
        end
      end
    end
    preloadRegs(12'o0000, 1'b0, 12'o0);
    runInstruction("sza cla", 12'o7640, 1'b0);
    preloadRegs(12'o4321, 1'b0, 12'o0);
    runInstruction("sma cla", 12'o7700, 1'b0);
    switches = 12'o5252;
    preloadRegs(12'o0101, 1'b0, 12'o0);
    runInstruction("osr", 12'o7404, 1'b0);
    runInstruction("cla osr", 12'o7604, 1'b0);
    runInstruction("hlt", 12'o7402, 1'b0);
    runInstruction("nop after hlt", 12'o7400, 1'b0);
    preloadRegs(12'o0000, 1'b0, 12'o0);
    if (reportMismatch("load clears halt", "halt", 12'o0, 12'(halt))) stimulusErrors++;
    runInstruction("osr hlt", 12'o7406, 1'b0);

    // ####################################################################
    // group 3.
    // ####################################################################
    foreach (mqOps[opIdx]) begin
      repeat (2) begin
        preloadRegs(randomWord(), 1'b0, randomWord());
        runInstruction($sformatf("mq op %o", mqOps[opIdx]), mqOps[opIdx], 1'b0);
      end
    end
    foreach (eaeOps[opIdx]) begin
      preloadRegs(randomWord(), 1'b1, randomWord());
      runInstruction($sformatf("eae %o", eaeOps[opIdx]), eaeOps[opIdx], 1'b0);
    end
    for (j = 0; j < 100; j++) begin
      if (j % 4 == 0) begin
        preloadRegs(randomWord(), 1'b0, randomWord());
      end
      w = randomWord();
      runInstruction($sformatf("group3 %o", {4'b1111, w[7:1], 1'b1}),
        {4'b1111, w[7:1], 1'b1}, 1'b0);
    end

    // inputs pulsed while busy must not disturb the result.
    preloadRegs(12'o0017, 1'b0, 12'o0770);
    runInstruction("busy ignores inputs", 12'o7001, 1'b1);
    repeat (8) begin
      @(negedge CLK);
      if (done || busy) begin
        $display("done or busy rose again after start was pulsed while busy");
        stimulusErrors++;
      end
    end
    if (reportMismatch("busy ignores inputs", "ac", expAc, ac)) stimulusErrors++;
    if (reportMismatch("busy ignores inputs", "mq", expMq, mq)) stimulusErrors++;
    if (reportMismatch("busy ignores inputs", "link", 12'(expLink), 12'(link))) stimulusErrors++;

    $display("checks %0d, compare errors %0d, other errors %0d",
      compareChecks, compareErrors, stimulusErrors);
    if (compareErrors + stimulusErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/oprUnit_chk.sv ====
`default_nettype none

module oprUnitChk (
  input logic CLK,
  input logic reset,
  input logic start,
  input logic busy,
  input logic done,
  input logic halt
);

  timeunit 1ns;
  timeprecision 100ps;

  logic accepted;

  // idle is the only state with busy and done both low.
  assign accepted = start && !busy && !done && !reset;

  doneAfterStart: assert property (@(posedge CLK) disable iff (reset)
    $past(accepted, 5) |-> done)
    else $error("done missing five cycles after an accepted start");

  doneOnlyAfterStart: assert property (@(posedge CLK) disable iff (reset)
    done |-> $past(accepted, 5))
    else $error("done without an accepted start five cycles before");

  busyDoneExclusive: assert property (@(posedge CLK) !(busy && done))
    else $error("busy and done high in the same cycle");

  quietAfterReset: assert property (@(posedge CLK) reset |=> (!done && !busy && !halt))
    else $error("done, busy or halt high in the cycle after reset");

endmodule

bind oprUnit oprUnitChk u_chk (
  .CLK   (CLK),
  .reset (reset),
  .start (start),
  .busy  (busy),
  .done  (done),
  .halt  (halt)
);

`default_nettype wire
